//--- Makefile
TOP = tb_fpu_rnd

.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir

# passes only if the pass message shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- rtl/fpu_align.sv
`timescale 1ns/1ps

module fpu_align (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s1_load_i,
  input  fpu_rnd_pkg::rnd_req_t req_i,
  output fpu_rnd_pkg::aligned_t aligned_o
);
  import fpu_rnd_pkg::*;

  logic               carry;      // fraction overflowed into bit 27
  logic [SHIFT_W-1:0] shr_amt;    // effective right shift
  logic               rsh;
  logic [SHIFT_W:0]   lost_w;     // bits that fall below the round position
  logic [FRAC_W-1:0]  lost_mask;
  logic [FRAC_W-1:0]  fract_sh;
  logic               sticky_r;
  logic               sticky_l;
  logic               sticky;
  logic [EXP_W-1:0]   exp_r_src;
  logic [EXP_W-1:0]   exp_sel;
  logic               sign_sel;
  aligned_t           s1_d;

  //////////////////////////////////////////////////
  // shift select
  //////////////////////////////////////////////////

  assign carry   = req_i.fract[FRAC_W-1];
  assign shr_amt = (|req_i.shr) ? req_i.shr : {{(SHIFT_W-1){1'b0}}, carry};
  assign rsh     = |shr_amt;

  assign fract_sh = rsh ? (req_i.fract >> shr_amt) : (req_i.fract << req_i.shl);

  // right shift: round lands on bit 2, so everything under shr+2 is lost
  assign lost_w    = {1'b0, shr_amt} + 6'd2;
  assign lost_mask = ~({FRAC_W{1'b1}} << lost_w);  // saturates to all ones
  assign sticky_r  = |(req_i.fract & lost_mask);

  // left shift keeps sticky bits only for tiny shifts
  always_comb begin
    case (req_i.shl)
      5'd0:    sticky_l = |req_i.fract[1:0];
      5'd1:    sticky_l = req_i.fract[0];
      default: sticky_l = 1'b0;  // sticky bits moved up into the fraction
    endcase
  end

  assign sticky = rsh ? sticky_r : sticky_l;

  //////////////////////////////////////////////////
  // exponent and sign
  //////////////////////////////////////////////////

  // adder has no separate right shift exponent
  assign exp_r_src = req_i.is_add ? req_i.exp_sh0 : req_i.exp_shr;

  always_comb begin
    if (|req_i.shr) exp_sel = exp_r_src;
    else if (|req_i.shl & ~carry) exp_sel = req_i.exp_shl;  // carry shift wins over shl
    else exp_sel = req_i.exp_sh0 + {{(EXP_W-1){1'b0}}, carry};  // carry shift
  end

  // exact zero of a true subtraction is -0 only when rounding down
  assign sign_sel = (req_i.is_add & req_i.sub_zero) ? (req_i.rmode == RM_TO_INFM)
                                                    : req_i.sign;

  always_comb begin
    s1_d          = '0;
    s1_d.sign     = sign_sel;
    s1_d.exp      = exp_sel;
    s1_d.fract    = fract_sh[26:3];  // hidden + 23 mantissa bits
    s1_d.rnd      = fract_sh[2];
    s1_d.sticky   = sticky;
    s1_d.inv      = req_i.inv;
    s1_d.inf      = req_i.inf;
    s1_d.snan     = req_i.snan;
    s1_d.qnan     = req_i.qnan;
    s1_d.nan_sign = req_i.nan_sign;
    s1_d.rmode    = req_i.rmode;
  end

  // stage 1 register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      aligned_o <= '0;
    end else if (s1_load_i) begin
      aligned_o <= s1_d;
    end
  end

endmodule

//--- rtl/fpu_pipe_ctrl.sv
`timescale 1ns/1ps

module fpu_pipe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic flush_i,      // drop everything in flight
  input  logic req_valid_i,
  input  logic rsp_ready_i,
  output logic req_ready_o,
  output logic s1_load_o,    // align stage takes a new item
  output logic s2_load_o,    // round stage takes item from stage 1
  output logic rsp_valid_o
);

  logic s1_full;  // stage occupancy
  logic s2_full;
  logic s1_free;
  logic s2_free;

  // stage 2 opens up when empty or its item leaves this cycle
  assign s2_free   = ~s2_full | rsp_ready_i;
  assign s2_load_o = s1_full & s2_free;

  // stage 1 opens up when empty or it moves on
  assign s1_free     = ~s1_full | s2_load_o;
  assign req_ready_o = s1_free & ~flush_i;  // nothing accepted into a flush
  assign s1_load_o   = req_valid_i & req_ready_o;

  assign rsp_valid_o = s2_full;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_full <= 1'b0;
      s2_full <= 1'b0;
    end else if (flush_i) begin
      s1_full <= 1'b0;
      s2_full <= 1'b0;
    end else begin
      if (s1_load_o) s1_full <= 1'b1;
      else if (s2_load_o) s1_full <= 1'b0;  // handed on, nothing new
      if (s2_load_o) s2_full <= 1'b1;
      else if (rsp_ready_i) s2_full <= 1'b0;  // taken by the sink
    end
  end

endmodule

//--- rtl/fpu_rnd_pkg.sv
package fpu_rnd_pkg;

  //////////////////////////////////////////////////
  // widths and limits
  //////////////////////////////////////////////////

  localparam int unsigned EXP_W   = 10;  // biased exp + carry + sign room
  localparam int unsigned FRAC_W  = 28;  // carry, hidden, 23 mant, round, 2 sticky
  localparam int unsigned SHIFT_W = 5;

  localparam logic [EXP_W-1:0] EXP_MAX = 10'd254;  // largest finite exponent

  // 31-bit payloads, sign goes on top
  localparam logic [30:0] INF_BITS  = {8'hff, 23'd0};
  localparam logic [30:0] QNAN_BITS = {8'hff, 1'b1, 22'd0};
  localparam logic [30:0] SNAN_BITS = {8'hff, 1'b0, {22{1'b1}}};

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,  // ties to even
    RM_TO_ZERO = 2'd1,
    RM_TO_INFP = 2'd2,
    RM_TO_INFM = 2'd3
  } rmode_e;

  //////////////////////////////////////////////////
  // pipeline payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic               is_add;    // adder result, else multiplier
    logic               sign;
    logic               sub_zero;  // true subtraction gave exact zero
    logic [SHIFT_W-1:0] shr;
    logic [SHIFT_W-1:0] shl;
    logic [EXP_W-1:0]   exp_shr;
    logic [EXP_W-1:0]   exp_shl;
    logic [EXP_W-1:0]   exp_sh0;
    logic [FRAC_W-1:0]  fract;
    logic               inv;
    logic               inf;
    logic               snan;
    logic               qnan;
    logic               nan_sign;
    rmode_e             rmode;     // per item, several can be in flight
  } rnd_req_t;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [23:0]      fract;   // hidden bit + mantissa
    logic             rnd;
    logic             sticky;
    logic             inv;
    logic             inf;
    logic             snan;
    logic             qnan;
    logic             nan_sign;
    rmode_e           rmode;
  } aligned_t;

  typedef struct packed {
    logic inexact;
    logic overflow;
    logic underflow;
    logic infinity;
    logic zero;
    logic invalid;
  } fpu_flags_t;

  // ieee single fields
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fpu_fields_t;

  typedef union packed {
    logic [31:0] bits;  // raw view
    fpu_fields_t f;     // field view
  } fpu_word_u;

  typedef struct packed {
    fpu_word_u  word;
    fpu_flags_t flags;
  } rnd_rsp_t;

endpackage

//--- rtl/fpu_rnd_top.sv
`timescale 1ns/1ps

module fpu_rnd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush_i,
  input  logic                  req_valid_i,
  input  fpu_rnd_pkg::rnd_req_t req_i,
  input  logic                  rsp_ready_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output fpu_rnd_pkg::rnd_rsp_t rsp_o
);
  import fpu_rnd_pkg::*;

  logic     s1_load;   // align register enable
  logic     s2_load;   // round register enable
  aligned_t aligned;   // stage 1 to stage 2

  // occupancy and handshakes
  fpu_pipe_ctrl i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .rsp_ready_i (rsp_ready_i),
    .req_ready_o (req_ready_o),
    .s1_load_o   (s1_load),
    .s2_load_o   (s2_load),
    .rsp_valid_o (rsp_valid_o)
  );

  fpu_align i_align (
    .clk       (clk),
    .rst       (rst),
    .s1_load_i (s1_load),
    .req_i     (req_i),
    .aligned_o (aligned)
  );

  fpu_round i_round (
    .clk       (clk),
    .rst       (rst),
    .s2_load_i (s2_load),
    .aligned_i (aligned),
    .rsp_o     (rsp_o)
  );

endmodule

//--- rtl/fpu_round.sv
`timescale 1ns/1ps

module fpu_round (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s2_load_i,
  input  fpu_rnd_pkg::aligned_t aligned_i,
  output fpu_rnd_pkg::rnd_rsp_t rsp_o
);
  import fpu_rnd_pkg::*;

  logic             g;           // fraction lsb
  logic             r;
  logic             s;
  logic             lost;        // any precision dropped
  logic             rnd_up;
  logic [24:0]      fract_rnd;   // one extra bit for the rounding carry
  logic             renorm;
  logic [EXP_W-1:0] exp_rnd;
  logic [23:0]      fract24;
  logic             denorm;
  logic             ovf_range;
  fpu_word_u        res_word;
  fpu_flags_t       res_flags;
  rnd_rsp_t         s2_d;

  //////////////////////////////////////////////////
  // rounding
  //////////////////////////////////////////////////

  assign g    = aligned_i.fract[0];
  assign r    = aligned_i.rnd;
  assign s    = aligned_i.sticky;
  assign lost = r | s;

  // to zero never rounds up, it just truncates
  assign rnd_up = ((aligned_i.rmode == RM_NEAREST) & r & s) |
                  ((aligned_i.rmode == RM_NEAREST) & r & ~s & g) |  // tie, go even
                  ((aligned_i.rmode == RM_TO_INFP) & ~aligned_i.sign & lost) |
                  ((aligned_i.rmode == RM_TO_INFM) & aligned_i.sign & lost);

  assign fract_rnd = {1'b0, aligned_i.fract} + {24'd0, rnd_up};

  // mantissa all ones rolled over
  assign renorm  = fract_rnd[24];
  assign exp_rnd = aligned_i.exp + {{(EXP_W-1){1'b0}}, renorm};
  assign fract24 = renorm ? fract_rnd[24:1] : fract_rnd[23:0];

  assign denorm    = ~fract24[23];               // no hidden bit left
  assign ovf_range = exp_rnd > EXP_MAX;          // also catches wrapped negatives

  //////////////////////////////////////////////////
  // special values and packing
  //////////////////////////////////////////////////

  always_comb begin
    res_word.bits = '0;
    res_flags     = '0;
    if (aligned_i.snan | aligned_i.qnan) begin
      // nan input wins, result always quiet
      res_word.f.sign = aligned_i.nan_sign;
      {res_word.f.exponent, res_word.f.mantissa} = QNAN_BITS;
      res_flags.invalid = aligned_i.snan;
    end else if (aligned_i.inv) begin
      res_word.f.sign = aligned_i.sign;
      {res_word.f.exponent, res_word.f.mantissa} = SNAN_BITS;
      res_flags.invalid = 1'b1;
    end else if (ovf_range | aligned_i.inf) begin
      res_word.f.sign = aligned_i.sign;
      {res_word.f.exponent, res_word.f.mantissa} = INF_BITS;
      res_flags.infinity = 1'b1;
      res_flags.overflow = ~aligned_i.inf;         // only a real overflow
      res_flags.inexact  = ~aligned_i.inf | lost;
    end else if (denorm) begin
      res_word.f.sign     = aligned_i.sign;
      res_word.f.exponent = 8'd0;
      res_word.f.mantissa = fract24[22:0];
      res_flags.inexact   = lost;
      res_flags.underflow = lost;                  // tiny and inexact
      res_flags.zero      = ~(|fract24);
    end else begin
      res_word.f.sign     = aligned_i.sign;
      res_word.f.exponent = exp_rnd[7:0];
      res_word.f.mantissa = fract24[22:0];         // hidden bit dropped
      res_flags.inexact   = lost;
    end
  end

  assign s2_d.word  = res_word;
  assign s2_d.flags = res_flags;

  // output register, holds while the sink stalls
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_o <= '0;
    end else if (s2_load_i) begin
      rsp_o <= s2_d;
    end
  end

endmodule

//--- sources.f
+incdir+verification
rtl/fpu_rnd_pkg.sv
rtl/fpu_pipe_ctrl.sv
rtl/fpu_align.sv
rtl/fpu_round.sv
rtl/fpu_rnd_top.sv
verification/tb_clkgen.sv
verification/tb_fpu_rnd.sv

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  // reset held for 10 cycles, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// align step, one request to the aligned form
function automatic aligned_t model_align(input rnd_req_t q);
  aligned_t    a;
  logic [27:0] f;
  int          amt;
  int          i;
  a   = '0;
  amt = (|q.shr) ? int'(q.shr) : int'(q.fract[27]);  // carry means shift by one
  if (amt != 0) begin
    f = q.fract >> amt;
    // round ends up at bit 2, so all bits under amt+2 are gone
    for (i = 0; i < amt + 2 && i < 28; i++)
      a.sticky = a.sticky | q.fract[i];
    a.exp = (|q.shr) ? (q.is_add ? q.exp_sh0 : q.exp_shr) : q.exp_sh0 + 10'd1;
  end else begin
    f        = q.fract << q.shl;
    a.sticky = (q.shl == 5'd0) ? |q.fract[1:0] : (q.shl == 5'd1) ? q.fract[0] : 1'b0;
    a.exp    = (q.shl == 5'd0) ? q.exp_sh0 : q.exp_shl;
  end
  a.sign  = (q.is_add & q.sub_zero) ? (q.rmode == RM_TO_INFM) : q.sign;
  a.fract = f[26:3];  // hidden + mantissa
  a.rnd   = f[2];
  {a.inv, a.inf, a.snan, a.qnan, a.nan_sign} = {q.inv, q.inf, q.snan, q.qnan, q.nan_sign};
  a.rmode = q.rmode;
  return a;
endfunction

// rounding, special values and flags
function automatic rnd_rsp_t model_round(input aligned_t a);
  rnd_rsp_t    o;
  logic        lost;
  logic        up;
  logic [24:0] sum;
  logic [9:0]  e;
  o    = '0;
  lost = a.rnd | a.sticky;
  case (a.rmode)
    RM_NEAREST: up = a.rnd & (a.sticky | a.fract[0]);  // tie goes to even
    RM_TO_INFP: up = lost & ~a.sign;
    RM_TO_INFM: up = lost & a.sign;
    default:    up = 1'b0;
  endcase
  sum = {1'b0, a.fract} + {24'd0, up};
  e   = a.exp + {9'd0, sum[24]};
  if (sum[24]) sum = sum >> 1;  // all ones rolled over
  if (a.snan | a.qnan) begin
    o.word.bits     = {a.nan_sign, QNAN_BITS};
    o.flags.invalid = a.snan;
  end else if (a.inv) begin
    o.word.bits     = {a.sign, SNAN_BITS};
    o.flags.invalid = 1'b1;
  end else if (e > EXP_MAX || a.inf) begin
    o.word.bits      = {a.sign, INF_BITS};
    o.flags.infinity = 1'b1;
    o.flags.overflow = ~a.inf;
    o.flags.inexact  = ~a.inf | lost;
  end else begin
    o.flags.inexact = lost;
    if (sum[23]) begin
      o.word.bits = {a.sign, e[7:0], sum[22:0]};
    end else begin
      // denormal or zero
      o.word.bits       = {a.sign, 8'd0, sum[22:0]};
      o.flags.underflow = lost;
      o.flags.zero      = (sum[23:0] == 24'd0);
    end
  end
  return o;
endfunction

function automatic rnd_rsp_t expected_rsp(input rnd_req_t q);
  return model_round(model_align(q));
endfunction

`endif

//--- verification/tb_fpu_rnd.sv
`timescale 1ns/1ps

module tb_fpu_rnd;
  import fpu_rnd_pkg::*;

  localparam logic [31:0] SEED = 32'h2cb2;
  localparam int N_EACH      = 300;                       // accepted requests per phase
  localparam int N_PHASE     = 6;
  localparam int WDOG_CYCLES = 20 * N_EACH * N_PHASE + 10;  // + reset
  localparam int K_NORMAL    = 0;                         // request kinds
  localparam int K_MODES     = 1;
  localparam int K_SPECIAL   = 2;
  localparam int K_EDGE      = 3;
  localparam int K_MIX       = 4;                         // any of the above

  logic        clk;
  logic        rst;
  logic        flush;
  logic        req_valid;
  logic        req_ready;
  logic        rsp_valid;
  logic        rsp_ready;
  rnd_req_t    req;
  rnd_rsp_t    rsp;
  logic [31:0] lfsr;
  rnd_rsp_t    exp_q[$];   // scoreboard, oldest first
  int          err_count;
  int          check_count;
  string       test_name;

  `include "tb_model.svh"

  tb_clkgen i_clkgen (.clk_o(clk), .rst_o(rst));

  fpu_rnd_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_ready_i (rsp_ready),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i] = lfsr[0];          // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_val(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("FAILED %s: expected %h actual %h", what, expected, actual);
    end
  endtask

  task automatic make_req(input int kind, output rnd_req_t r);
    logic [31:0] v;
    int          k;
    r = '0;
    k = kind;
    if (k == K_MIX) begin
      draw_bits(2, v);
      k = int'(v[1:0]);
    end
    draw_bits(30, v);
    {r.is_add, r.sign, r.fract} = v[29:0];
    draw_bits(24, v);
    r.exp_shr = {2'b00, v[7:0]};
    r.exp_shl = {2'b00, v[15:8]};
    r.exp_sh0 = {2'b00, v[23:16]};
    draw_bits(8, v);                               // shift style, amount
    case (v[1:0])
      2'd0: begin                                  // right shift, mostly short
        r.shr = v[2] ? v[7:3] : {2'b00, v[5:3]};
        if (r.shr == 5'd0) r.shr = 5'd1;
      end
      2'd1: begin                                  // carry shift, shl must be ignored
        r.fract[27] = 1'b1;
        r.shl       = v[7:3];
      end
      2'd2: begin
        r.fract[27] = 1'b0;
        r.shl       = v[2] ? v[7:3] : {2'b00, v[5:3]};
      end
      default: r.fract[27] = 1'b0;                 // already aligned
    endcase
    draw_bits(8, v);
    r.rmode = (k == K_NORMAL) ? RM_NEAREST : rmode_e'(v[1:0]);
    if (v[4:2] == 3'd0 && k <= K_MODES) begin      // exact tie, no shift
      {r.shr, r.shl} = '0;
      r.fract[27:26] = 2'b01;
      r.fract[2:0]   = 3'b100;
    end
    if (k == K_MODES && v[7:5] == 3'd0) begin      // exact zero, adder or multiplier
      r.sub_zero = 1'b1;
      r.fract    = '0;
      {r.shr, r.shl} = '0;
    end
    if (k == K_SPECIAL) begin
      draw_bits(10, v);
      {r.inv, r.inf, r.snan, r.qnan, r.nan_sign} = v[4:0] & v[9:5];
    end
    if (k == K_EDGE) begin
      draw_bits(4, v);
      if (v[0]) begin
        r.exp_shr = 10'd250 + {7'd0, v[3:1]};      // around the top of the range
        r.exp_shl = r.exp_shr;
        r.exp_sh0 = r.exp_shr;
        if (v[2]) r.fract[25:3] = '1;              // rounding may carry over
      end else begin
        {r.shr, r.shl} = '0;                       // no hidden bit
        r.fract[27:26] = 2'b00;
        if (v[1]) r.fract[25:3] = '0;
      end
    end
  endtask

  // inputs set at the falling edge; book the handshakes of the coming edge
  task automatic track_cycle(input bit after_flush, output bit req_fire);
    rnd_rsp_t want;
    #1;
    if (after_flush) begin
      check_val({test_name, " valid after flush"}, 64'(0), 64'(rsp_valid));
      check_val({test_name, " ready after flush"}, 64'(1), 64'(req_ready));
    end
    if (rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("%s: a response arrived with no request in flight", test_name);
      end else begin
        want = exp_q.pop_front();
        check_val({test_name, " word"}, 64'(want.word.bits), 64'(rsp.word.bits));
        check_val({test_name, " flags"}, 64'(want.flags), 64'(rsp.flags));
      end
    end
    req_fire = req_valid & req_ready;
    if (req_fire)
      exp_q.push_back(expected_rsp(req));
    if (flush)
      exp_q.delete();  // every item in flight is dropped
    @(negedge clk);
  endtask

  task automatic run_phase(input string name, input int kind, input bit stall,
                           input bit flushes);
    logic [31:0] v;
    bit          hold;
    bit          fired;
    bit          was_flush;
    int          accepted;
    test_name = name;
    hold      = 1'b0;
    was_flush = 1'b0;
    accepted  = 0;
    while (accepted < N_EACH) begin
      if (!hold) begin
        make_req(kind, req);
        draw_bits(2, v);
        req_valid = ~stall | (v[1:0] != 2'd0);   // idle one time in four
      end
      draw_bits(1, v);
      rsp_ready = ~stall | v[0];
      draw_bits(4, v);
      flush = flushes & ~was_flush & (v[3:0] == 4'd0);
      if (flush)
        rsp_ready = 1'b0;                        // nothing leaves in a flush cycle
      track_cycle(was_flush, fired);
      was_flush = flush;
      hold      = req_valid & ~fired;            // request stays put until taken
      if (fired)
        accepted++;
    end
    req_valid = 1'b0;                            // drain, sink always ready
    rsp_ready = 1'b1;
    flush     = 1'b0;
    track_cycle(was_flush, fired);
    while (exp_q.size() != 0)
      track_cycle(1'b0, fired);
    repeat (3) track_cycle(1'b0, fired);         // duplicates would show here
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    lfsr        = SEED;
    err_count   = 0;
    check_count = 0;
    test_name   = "reset";
    req         = '0;
    req_valid   = 1'b0;
    rsp_ready   = 1'b0;
    flush       = 1'b0;
    @(negedge rst);
    @(negedge clk);
    #1;
    check_val("reset rsp_valid", 64'(0), 64'(rsp_valid));
    check_val("reset req_ready", 64'(1), 64'(req_ready));
    @(negedge clk);
    run_phase("normal_nearest", K_NORMAL, 1'b0, 1'b0);
    run_phase("rounding_modes", K_MODES, 1'b0, 1'b0);
    run_phase("specials", K_SPECIAL, 1'b0, 1'b0);
    run_phase("exponent_edges", K_EDGE, 1'b0, 1'b0);
    run_phase("backpressure", K_MIX, 1'b1, 1'b0);
    run_phase("flush", K_MIX, 1'b1, 1'b1);
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
